// File: Bender.yml
package:
  name: lspLsf

export_include_dirs:
  - include

sources:
  - files:
      - logic/lspLsfPkg.sv
      - logic/g729BasicOps.sv
      - logic/acosTableRom.sv
      - logic/scratchMem.sv
      - logic/lspLsfFsm.sv
      - logic/lspLsfPipe.sv
  - target: test
    files:
      - testbench/lspLsfTb.sv

// File: include/acosTables.svh
// Arccosine search table of the LSP to LSF conversion
// Cosine of (index * pi / 64) in Q15, falling from 32767 to -32729
localparam logic signed [15:0] acosTable2 [0:63] = '{
  32767,  32729,  32610,  32413,  32138,  31786,  31357,  30853,
  30274,  29622,  28899,  28106,  27246,  26320,  25330,  24279,
  23170,  22006,  20788,  19520,  18205,  16846,  15447,  14010,
  12540,  11039,   9512,   7962,   6393,   4808,   3212,   1608,
      0,  -1608,  -3212,  -4808,  -6393,  -7962,  -9512, -11039,
 -12540, -14010, -15447, -16846, -18205, -19520, -20788, -22006,
 -23170, -24279, -25330, -26320, -27246, -28106, -28899, -29622,
 -30274, -30853, -31357, -31786, -32138, -32413, -32610, -32729
};

// Slope for linear interpolation between neighbouring table entries
// Symmetric about the middle of the table
localparam logic signed [15:0] acosSlope [0:63] = '{
 -26887,  -8812,  -5323,  -3813,  -2979,  -2444,  -2081,  -1811,
  -1608,  -1450,  -1322,  -1219,  -1132,  -1059,   -998,   -946,
   -901,   -861,   -827,   -797,   -772,   -750,   -730,   -713,
   -699,   -687,   -677,   -668,   -662,   -657,   -654,   -652,
   -652,   -654,   -657,   -662,   -668,   -677,   -687,   -699,
   -713,   -730,   -750,   -772,   -797,   -827,   -861,   -901,
   -946,   -998,  -1059,  -1132,  -1219,  -1322,  -1450,  -1608,
  -1811,  -2081,  -2444,  -2979,  -3813,  -5323,  -8812, -26887
};

// File: logic/acosTableRom.sv
`timescale 1ns/10ps

module acosTableRom
(
  input  logic                                clk,
  input  logic [lspLsfPkg::constAddrWidth-1:0] addr,
  output logic [lspLsfPkg::wordWidth-1:0]      data
);
  import lspLsfPkg::*;

  `include "acosTables.svh"

  logic [$clog2(tableSize)-1:0] entry;

  // Low address bits select the entry inside either table
  assign entry = addr[$clog2(tableSize)-1:0];

  // Registered read, sign-extended to a full word
  always_ff @(posedge clk)
  begin
    if ((addr >= tableBase) && (addr < tableBase + tableSize))
    begin
      data <= wordWidth'(acosTable2[entry]);
    end
    else if ((addr >= slopeBase) && (addr < slopeBase + tableSize))
    begin
      data <= wordWidth'(acosSlope[entry]);
    end
    else
    begin
      // Unpopulated range
      data <= '0;
    end
  end

endmodule

// File: logic/g729BasicOps.sv
`timescale 1ns/10ps

module g729BasicOps
(
  input  logic signed [15:0] subA,
  input  logic signed [15:0] subB,
  output logic signed [15:0] subDiff,
  input  logic signed [15:0] lMultA,
  input  logic signed [15:0] lMultB,
  output logic signed [31:0] lMultProduct,
  input  logic signed [31:0] lShrVar,
  input  logic [4:0]         lShrAmount,
  output logic signed [31:0] lShrResult,
  input  logic signed [15:0] shlVar,
  input  logic [3:0]         shlAmount,
  output logic signed [15:0] shlResult,
  input  logic signed [15:0] addA,
  input  logic signed [15:0] addB,
  output logic signed [15:0] addSum,
  input  logic signed [15:0] multA,
  input  logic signed [15:0] multB,
  output logic signed [15:0] multProduct
);

  logic signed [16:0] subWide;
  logic signed [16:0] addWide;
  logic signed [31:0] lMultRaw;
  logic signed [31:0] shlWide;
  logic signed [31:0] multRaw;
  logic signed [31:0] multShifted;

  // Clamp a 17-bit intermediate into the 16-bit range
  function automatic logic signed [15:0] sat16(input logic signed [16:0] value);
    if (value > 17'sd32767)
    begin
      return 16'sh7fff;
    end
    else if (value < -17'sd32768)
    begin
      return 16'sh8000;
    end
    return value[15:0];
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // sub and add

  assign subWide = 17'(subA) - 17'(subB);
  assign subDiff = sat16(subWide);

  assign addWide = 17'(addA) + 17'(addB);
  assign addSum  = sat16(addWide);

  ////////////////////////////////////////////////////////////////////////////
  // L_mult and L_shr

  // Doubled product, only -1 * -1 overflows
  assign lMultRaw     = lMultA * lMultB;
  assign lMultProduct = (lMultRaw == 32'sh4000_0000) ? 32'sh7fff_ffff : (lMultRaw <<< 1);

  // Arithmetic shift, sign fills from the top
  assign lShrResult = lShrVar >>> lShrAmount;

  ////////////////////////////////////////////////////////////////////////////
  // shl and mult

  // Shift in 32 bits, then clamp to the sign of the input
  assign shlWide = 32'(shlVar) <<< shlAmount;

  always_comb
  begin
    if (shlWide > 32'sd32767)
    begin
      shlResult = 16'sh7fff;
    end
    else if (shlWide < -32'sd32768)
    begin
      shlResult = 16'sh8000;
    end
    else
    begin
      shlResult = shlWide[15:0];
    end
  end

  // Q15 product, keeps bits 30..15
  assign multRaw     = multA * multB;
  assign multShifted = multRaw >>> 15;
  assign multProduct = sat16(multShifted[16:0]);

endmodule

// File: logic/lspLsfFsm.sv
`timescale 1ns/10ps

module lspLsfFsm
(
  input  logic                                   clk,
  input  logic                                   rstN,
  input  logic                                   start,
  input  logic [lspLsfPkg::scratchAddrWidth-1:0] lspAddr,
  input  logic [lspLsfPkg::scratchAddrWidth-1:0] lsfAddr,
  input  logic [lspLsfPkg::wordWidth-1:0]        memIn,
  input  logic [lspLsfPkg::wordWidth-1:0]        constantMemIn,
  // Operator results, same cycle
  input  logic signed [15:0]                     subDiff,
  input  logic signed [31:0]                     lMultProduct,
  input  logic signed [31:0]                     lShrResult,
  input  logic signed [15:0]                     shlResult,
  input  logic signed [15:0]                     addSum,
  input  logic signed [15:0]                     multProduct,
  // Operator operands
  output logic signed [15:0]                     subA,
  output logic signed [15:0]                     subB,
  output logic signed [15:0]                     lMultA,
  output logic signed [15:0]                     lMultB,
  output logic signed [31:0]                     lShrVar,
  output logic [4:0]                             lShrAmount,
  output logic signed [15:0]                     shlVar,
  output logic [3:0]                             shlAmount,
  output logic signed [15:0]                     addA,
  output logic signed [15:0]                     addB,
  output logic signed [15:0]                     multA,
  output logic signed [15:0]                     multB,
  // Memories
  output logic [lspLsfPkg::scratchAddrWidth-1:0] memReadAddr,
  output logic [lspLsfPkg::scratchAddrWidth-1:0] memWriteAddr,
  output logic [lspLsfPkg::wordWidth-1:0]        memOut,
  output logic                                   memWriteEn,
  output logic [lspLsfPkg::constAddrWidth-1:0]   constantMemAddr,
  output logic                                   done
);
  import lspLsfPkg::*;

  typedef logic [$clog2(tableSize)-1:0] indexT;
  typedef logic [$clog2(lpcOrder)-1:0]  coefT;

  fsmState state;
  coefT    coefIdx;
  indexT   ind;
  indexT   indNext;

  logic signed [15:0] lsp;
  logic signed [15:0] tableVal;
  logic signed [15:0] offset;
  logic signed [15:0] freq;
  logic signed [31:0] product;

  assign indNext = ind - 1'b1;

  ////////////////////////////////////////////////////////////////////////////
  // Memory addressing

  // Coefficients run from lpcOrder-1 down to 0
  assign memReadAddr = lspAddr + scratchAddrWidth'(coefIdx);

  always_comb
  begin
    constantMemAddr = tableBase + constAddrWidth'(ind);
    if (state == compare)
    begin
      // Prefetch the next lower entry in case the search goes on
      constantMemAddr = tableBase + constAddrWidth'(indNext);
    end
    else if (state == readSlope)
    begin
      constantMemAddr = slopeBase + constAddrWidth'(ind);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Operator operands

  // sub serves both the search test and the offset
  always_comb
  begin
    subA = tableVal;
    subB = lsp;
    if (state == readSlope)
    begin
      subA = lsp;
      subB = tableVal;
    end
  end

  // Slope word is on the ROM output during waitSlope
  assign lMultA = constantMemIn[15:0];
  assign lMultB = offset;

  assign lShrVar    = product;
  assign lShrAmount = slopeShift;
  assign shlVar     = 16'(ind);
  assign shlAmount  = indexShift;

  // extract_l of the shifted product
  assign addA = shlResult;
  assign addB = lShrResult[15:0];

  assign multA = freq;
  assign multB = lsfScale;

  ////////////////////////////////////////////////////////////////////////////
  // Control

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      state      <= idle;
      coefIdx    <= '0;
      ind        <= '0;
      memWriteEn <= 1'b0;
      done       <= 1'b0;
    end
    else
    begin
      done       <= 1'b0;
      memWriteEn <= 1'b0;
      case (state)
        idle:
        begin
          if (start)
          begin
            coefIdx <= coefT'(lpcOrder - 1);
            ind     <= indexT'(tableSize - 1);
            state   <= readLsp;
          end
        end
        readLsp:   state <= waitLsp;
        waitLsp:   state <= readTable;
        readTable: state <= waitTable;
        waitTable: state <= compare;
        compare:
        begin
          // Table entry still below lsp, keep descending
          // Index carries over to the next coefficient
          if ((subDiff < 0) && (ind != '0))
          begin
            ind   <= indNext;
            state <= waitTable;
          end
          else
          begin
            state <= readSlope;
          end
        end
        readSlope: state <= waitSlope;
        waitSlope: state <= interp;
        interp:    state <= scale;
        scale:     state <= writeLsf;
        writeLsf:
        begin
          // Write lands in the following cycle
          memWriteEn <= 1'b1;
          if (coefIdx == '0)
          begin
            state <= finish;
          end
          else
          begin
            coefIdx <= coefIdx - 1'b1;
            state   <= readLsp;
          end
        end
        finish:
        begin
          done  <= 1'b1;
          state <= idle;
        end
        default: state <= idle;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Datapath registers

  always_ff @(posedge clk)
  begin
    case (state)
      waitLsp:   lsp      <= memIn[15:0];
      waitTable: tableVal <= constantMemIn[15:0];
      readSlope: offset   <= subDiff;
      waitSlope: product  <= lMultProduct;
      interp:    freq     <= addSum;
      scale:
      begin
        memOut       <= wordWidth'(multProduct);
        memWriteAddr <= lsfAddr + scratchAddrWidth'(coefIdx);
      end
      default: ;
    endcase
  end

endmodule

// File: logic/lspLsfPipe.sv
`timescale 1ns/10ps

module lspLsfPipe
(
  input  logic                                   clk,
  input  logic                                   rstN,
  input  logic                                   start,
  input  logic [lspLsfPkg::scratchAddrWidth-1:0] lspAddr,
  input  logic [lspLsfPkg::scratchAddrWidth-1:0] lsfAddr,
  input  logic [lspLsfPkg::scratchAddrWidth-1:0] testReadAddr,
  input  logic [lspLsfPkg::scratchAddrWidth-1:0] testWriteAddr,
  input  logic [lspLsfPkg::wordWidth-1:0]        testMemOut,
  input  logic                                   testWriteEn,
  input  logic                                   memMuxSel,
  output logic                                   done,
  output logic [lspLsfPkg::wordWidth-1:0]        memIn
);
  import lspLsfPkg::*;

  logic signed [15:0] subA, subB, subDiff;
  logic signed [15:0] lMultA, lMultB;
  logic signed [31:0] lMultProduct;
  logic signed [31:0] lShrVar, lShrResult;
  logic [4:0]         lShrAmount;
  logic signed [15:0] shlVar, shlResult;
  logic [3:0]         shlAmount;
  logic signed [15:0] addA, addB, addSum;
  logic signed [15:0] multA, multB, multProduct;

  logic [scratchAddrWidth-1:0] memReadAddr, memWriteAddr;
  logic [wordWidth-1:0]        memOut;
  logic                        memWriteEn;
  logic [constAddrWidth-1:0]   constantMemAddr;
  logic [wordWidth-1:0]        constantMemIn;

  logic [scratchAddrWidth-1:0] muxReadAddr, muxWriteAddr;
  logic [wordWidth-1:0]        muxWriteData;
  logic                        muxWriteEn;

  lspLsfFsm fsm (.*);

  g729BasicOps ops (.*);

  acosTableRom constRom
  (
    .clk  (clk),
    .addr (constantMemAddr),
    .data (constantMemIn)
  );

  scratchMem scratch
  (
    .clk       (clk),
    .writeAddr (muxWriteAddr),
    .writeData (muxWriteData),
    .writeEn   (muxWriteEn),
    .readAddr  (muxReadAddr),
    .readData  (memIn)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Test port muxes, high hands the scratch RAM to the controller

  assign muxReadAddr  = memMuxSel ? memReadAddr  : testReadAddr;
  assign muxWriteAddr = memMuxSel ? memWriteAddr : testWriteAddr;
  assign muxWriteData = memMuxSel ? memOut       : testMemOut;
  assign muxWriteEn   = memMuxSel ? memWriteEn   : testWriteEn;

endmodule

// File: logic/lspLsfPkg.sv
package lspLsfPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Memory geometry

  // Scratch and ROM words, LSP and LSF values live in the low half
  localparam int wordWidth        = 32;
  localparam int scratchAddrWidth = 11;
  localparam int scratchDepth     = 2048;
  localparam int constAddrWidth   = 12;

  ////////////////////////////////////////////////////////////////////////////
  // Constant ROM layout

  localparam int tableSize = 64;

  // Both bases are multiples of tableSize
  localparam logic [constAddrWidth-1:0] tableBase = 12'd0;
  localparam logic [constAddrWidth-1:0] slopeBase = 12'd64;

  ////////////////////////////////////////////////////////////////////////////
  // Conversion constants

  // Coefficients per block
  localparam int lpcOrder = 10;

  // Interpolation product back to Q9 fraction
  localparam logic [4:0] slopeShift = 5'd12;

  // Table index to integer part of the frequency
  localparam logic [3:0] indexShift = 4'd9;

  // Final scale to the LSF domain
  localparam logic signed [15:0] lsfScale = 16'sd25736;

  // Controller states
  typedef enum logic [3:0] {
    idle,
    readLsp,
    waitLsp,
    readTable,
    waitTable,
    compare,
    readSlope,
    waitSlope,
    interp,
    scale,
    writeLsf,
    finish
  } fsmState;

endpackage

// File: logic/scratchMem.sv
`timescale 1ns/10ps

module scratchMem
(
  input  logic                                   clk,
  input  logic [lspLsfPkg::scratchAddrWidth-1:0] writeAddr,
  input  logic [lspLsfPkg::wordWidth-1:0]        writeData,
  input  logic                                   writeEn,
  input  logic [lspLsfPkg::scratchAddrWidth-1:0] readAddr,
  output logic [lspLsfPkg::wordWidth-1:0]        readData
);
  import lspLsfPkg::*;

  logic [wordWidth-1:0] mem [0:scratchDepth-1];

  // Write port
  always_ff @(posedge clk)
  begin
    if (writeEn)
    begin
      mem[writeAddr] <= writeData;
    end
  end

  // Read port, one cycle latency
  // A colliding write shows up on the following read
  always_ff @(posedge clk)
  begin
    readData <= mem[readAddr];
  end

endmodule

// File: lspLsf.f
+incdir+include
logic/lspLsfPkg.sv
logic/g729BasicOps.sv
logic/acosTableRom.sv
logic/scratchMem.sv
logic/lspLsfFsm.sv
logic/lspLsfPipe.sv
testbench/lspLsfTb.sv

// File: testbench/lspLsfTb.sv
`timescale 1ns/10ps

module lspLsfTb;
  import lspLsfPkg::*;

  `include "acosTables.svh"

  // Worst run is about 230 conversion cycles plus test-port traffic
  localparam int maxRuns      = 40;
  localparam int cyclesPerRun = 250;
  localparam int cycleLimit   = maxRuns * cyclesPerRun;

  logic                        clk;
  logic                        rstN;
  logic                        start;
  logic [scratchAddrWidth-1:0] lspAddr;
  logic [scratchAddrWidth-1:0] lsfAddr;
  logic [scratchAddrWidth-1:0] testReadAddr;
  logic [scratchAddrWidth-1:0] testWriteAddr;
  logic [wordWidth-1:0]        testMemOut;
  logic                        testWriteEn;
  logic                        memMuxSel;
  logic                        done;
  logic [wordWidth-1:0]        memIn;

  int cycleCount;
  int doneCount;
  int lspVals [0:lpcOrder-1];
  int expLsf [0:lpcOrder-1];

  // Table hits, top and bottom of range, equal neighbours, unsorted extremes
  int edgeSets [0:4][0:9] = '{
    '{30853, 26320, 16846, 3212, 0, -9512, -18205, -25330, -30853, -32729},
    '{10{32767}},
    '{32767, 32767, 20000, 20000, 0, 0, -1608, -1608, -32768, -32768},
    '{10{-32768}},
    '{-32768, 32767, -32768, 32767, -32768, 32767, -32768, 32767, -32768, 32767}
  };

  lspLsfPipe dut0
  (
    .clk           (clk),
    .rstN          (rstN),
    .start         (start),
    .lspAddr       (lspAddr),
    .lsfAddr       (lsfAddr),
    .testReadAddr  (testReadAddr),
    .testWriteAddr (testWriteAddr),
    .testMemOut    (testMemOut),
    .testWriteEn   (testWriteEn),
    .memMuxSel     (memMuxSel),
    .done          (done),
    .memIn         (memIn)
  );

  always #10 clk = ~clk;

  always @(posedge clk)
  begin
    cycleCount++;
    if (rstN && (done === 1'b1))
      doneCount++;
    if (cycleCount >= cycleLimit)
      reportFail($sformatf("Run did not finish within %0d clock cycles", cycleLimit));
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reporting

  task automatic reportFail(input string reason);
    $display("%s", reason);
    $display("SOME TESTS FAILED");
    $fatal(1, "Stopped at the first failure");
  endtask

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("ERROR at %0d ns: %s expected %h, actual %h", $time, name, expected, actual);
      reportFail("Value mismatch");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model of the saturating G.729 operators

  function automatic int sat16(input longint value);
    if (value > 32767)
      return 32767;
    if (value < -32768)
      return -32768;
    return int'(value);
  endfunction

  function automatic int subOp(input int a, input int b);
    return sat16(longint'(a) - b);
  endfunction

  function automatic int addOp(input int a, input int b);
    return sat16(longint'(a) + b);
  endfunction

  // Doubled product clamped to the 32-bit range
  function automatic int lMultOp(input int a, input int b);
    longint wide;
    wide = 2 * longint'(a) * longint'(b);
    if (wide > 64'sd2147483647)
      return 32'sh7fff_ffff;
    return int'(wide);
  endfunction

  function automatic int shlOp(input int value, input int amount);
    return sat16(longint'(value) <<< amount);
  endfunction

  function automatic int multOp(input int a, input int b);
    return sat16((longint'(a) * b) >>> 15);
  endfunction

  function automatic void modelConvert();
    int ind;
    int offset;
    int lTmp;
    int freq;
    logic signed [15:0] frac;
    ind = tableSize - 1;
    for (int i = lpcOrder - 1; i >= 0; i--)
    begin
      // Search carries on from where the previous coefficient stopped
      while ((subOp(acosTable2[ind], lspVals[i]) < 0) && (ind != 0))
        ind--;
      offset    = subOp(lspVals[i], acosTable2[ind]);
      lTmp      = lMultOp(acosSlope[ind], offset);
      frac      = 16'(lTmp >>> slopeShift);
      freq      = addOp(shlOp(ind, indexShift), frac);
      expLsf[i] = multOp(freq, lsfScale);
    end
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Test port and run control

  task automatic writeWord(input int addr, input int data);
    @(negedge clk);
    testWriteAddr = scratchAddrWidth'(addr);
    testMemOut    = data;
    testWriteEn   = 1'b1;
  endtask

  task automatic endWrites();
    @(negedge clk);
    testWriteEn = 1'b0;
  endtask

  task automatic readWord(input int addr, output logic [31:0] data);
    @(negedge clk);
    testReadAddr = scratchAddrWidth'(addr);
    @(negedge clk);
    data = memIn;
  endtask

  task automatic randomLsp();
    logic signed [15:0] r16;
    int tmp;
    for (int k = 0; k < lpcOrder; k++)
    begin
      r16 = 16'($urandom);
      lspVals[k] = r16;
    end
    // Descending order as the codec delivers them
    for (int a = 0; a < lpcOrder - 1; a++)
      for (int b = 0; b < lpcOrder - 1 - a; b++)
        if (lspVals[b] < lspVals[b + 1])
        begin
          tmp            = lspVals[b];
          lspVals[b]     = lspVals[b + 1];
          lspVals[b + 1] = tmp;
        end
  endtask

  task automatic loadLsp(input int addr);
    for (int k = 0; k < lpcOrder; k++)
      writeWord(addr + k, lspVals[k]);
    endWrites();
  endtask

  task automatic runConversion(input int lspA, input int lsfA, input bit startMuxLow);
    int countBefore;
    countBefore = doneCount;
    @(negedge clk);
    lspAddr   = scratchAddrWidth'(lspA);
    lsfAddr   = scratchAddrWidth'(lsfA);
    memMuxSel = !startMuxLow;
    start     = 1'b1;
    @(negedge clk);
    start     = 1'b0;
    memMuxSel = 1'b1;
    // Second start lands mid-run
    repeat (6) @(negedge clk);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    while (done !== 1'b1)
      @(negedge clk);
    @(negedge clk);
    checkValue("done", 1'b0, done);
    memMuxSel = 1'b0;
    @(negedge clk);
    checkValue("doneCount", countBefore + 1, doneCount);
  endtask

  task automatic checkLsf(input int lsfA);
    logic [31:0] got;
    modelConvert();
    for (int k = 0; k < lpcOrder; k++)
    begin
      readWord(lsfA + k, got);
      checkValue($sformatf("memIn[%0d]", lsfA + k), expLsf[k], got);
    end
  endtask

  // Guard words around the LSF block with the LSP block kept apart
  task automatic integrityRun();
    int lower;
    int upper;
    int lspA;
    int lsfA;
    int guardAddr [0:3];
    int guardVal [0:3];
    logic [31:0] got;
    lower = 2 + ($urandom % 1000);
    upper = lower + 24 + ($urandom % 1000);
    lspA  = ($urandom % 2) ? lower : upper;
    lsfA  = (lspA == lower) ? upper : lower;
    randomLsp();
    loadLsp(lspA);
    for (int j = 0; j < 4; j++)
    begin
      guardAddr[j] = (j < 2) ? (lsfA - 2 + j) : (lsfA + 8 + j);
      guardVal[j]  = $urandom;
      writeWord(guardAddr[j], guardVal[j]);
    end
    endWrites();
    runConversion(lspA, lsfA, 1'b0);
    checkLsf(lsfA);
    for (int j = 0; j < 4; j++)
    begin
      readWord(guardAddr[j], got);
      checkValue($sformatf("memIn[%0d]", guardAddr[j]), guardVal[j], got);
    end
    for (int k = 0; k < lpcOrder; k++)
    begin
      readWord(lspA + k, got);
      checkValue($sformatf("memIn[%0d]", lspA + k), lspVals[k], got);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence

  initial
  begin
    int base;
    int addrA;
    int words [0:15];
    logic [31:0] got;
    clk           = 1'b0;
    rstN          = 1'b0;
    start         = 1'b0;
    lspAddr       = '0;
    lsfAddr       = '0;
    testReadAddr  = '0;
    testWriteAddr = '0;
    testMemOut    = '0;
    testWriteEn   = 1'b0;
    memMuxSel     = 1'b0;
    cycleCount    = 0;
    doneCount     = 0;
    void'($urandom(32'h5683));
    repeat (2) @(negedge clk);
    rstN = 1'b1;

    // Quiet after reset and then a start with the test port still selected
    repeat (10)
    begin
      @(negedge clk);
      checkValue("done", 1'b0, done);
    end
    randomLsp();
    loadLsp(16);
    runConversion(16, 64, 1'b1);
    checkLsf(64);

    // Test-port round trip
    base = $urandom % (scratchDepth - 16);
    for (int k = 0; k < 16; k++)
    begin
      words[k] = $urandom;
      writeWord(base + k, words[k]);
    end
    endWrites();
    for (int k = 0; k < 16; k++)
    begin
      readWord(base + k, got);
      checkValue($sformatf("memIn[%0d]", base + k), words[k], got);
    end

    // Random blocks
    repeat (16)
    begin
      addrA = $urandom % 1000;
      base  = 1024 + ($urandom % 1000);
      randomLsp();
      loadLsp(addrA);
      runConversion(addrA, base, 1'b0);
      checkLsf(base);
    end

    for (int e = 0; e < 5; e++)
    begin
      for (int k = 0; k < lpcOrder; k++)
        lspVals[k] = edgeSets[e][k];
      loadLsp(200);
      runConversion(200, 700, 1'b0);
      checkLsf(700);
    end

    repeat (4) integrityRun();

    // In place conversion where each LSP is read before its slot is written
    repeat (3)
    begin
      addrA = $urandom % (scratchDepth - lpcOrder);
      randomLsp();
      loadLsp(addrA);
      runConversion(addrA, addrA, 1'b0);
      checkLsf(addrA);
    end

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule
